// ==== hdl/fe_pkg.sv ====
// Front end shared types
`default_nettype none

package fe_pkg;

  // Widths ----------------------------------
  localparam int WORD_W = 16;  // Machine word
  localparam int REG_W  = 4;   // Register number
  localparam int EXT_W  = 2;   // Extension word count, 0 to 2

  // Symbolic operand offset, the PC has already moved past the word
  localparam logic [WORD_W-1:0] SYMB_ADJ = 16'hFFFE;

  // Fetch sequencing ------------------------
  typedef enum logic [2:0] {
    S_OPC,   // Opcode read issued
    S_DEC,   // Opcode on the bus
    S_EXT1,  // First extension word on the bus
    S_EXT2,  // Second extension word on the bus
    S_OUT    // Instruction offered downstream
  } fetch_state_e;

  // Instruction format, from bits 15:13
  typedef enum logic [1:0] {
    TYPE_SO,   // 000
    TYPE_JMP,  // 001
    TYPE_TO    // Everything else
  } inst_type_e;

  // Opcodes ---------------------------------
  typedef enum logic [2:0] {
    RRC, SWPB, RRA, SXT, PUSH, CALL, RETI,
    SO_NONE    // Also the illegal code 7
  } so_op_e;

  // Jump condition, bits 12:10
  typedef enum logic [2:0] {
    JNE, JEQ, JNC, JC, JN, JGE, JL, JMP
  } jmp_op_e;

  // Bits 15:12, codes 0 to 3 are not two-operand
  typedef enum logic [3:0] {
    TO_NONE = 4'h0,
    MOV     = 4'h4, ADD  = 4'h5, ADDC = 4'h6, SUBC = 4'h7,
    SUB     = 4'h8, CMP  = 4'h9, DADD = 4'hA, BIT  = 4'hB,
    BIC     = 4'hC, BIS  = 4'hD, XOR  = 4'hE, AND  = 4'hF
  } to_op_e;

  // Addressing modes ------------------------
  typedef enum logic [2:0] {
    REG, IDX, INDIR, INDIR_INC, SYMB, IMM, ABS, CONST
  } src_mode_e;

  typedef enum logic [2:0] {
    D_NONE,  // No destination operand
    D_REG, D_IDX, D_SYMB, D_ABS
  } dst_mode_e;

endpackage

`default_nettype wire

// ==== hdl/fe_fetch_fsm.sv ====
// Fetch sequencer
`default_nettype none

module fe_fetch_fsm (
  input  logic                     mclk,
  input  logic                     puc,
  input  logic [fe_pkg::EXT_W-1:0] i_ext_cnt_nxt,  // From opcode on the bus
  input  logic [fe_pkg::EXT_W-1:0] i_ext_cnt,      // Latched with the opcode
  input  logic                     i_inst_ready,
  input  logic                     i_pc_sw_wr,
  output logic                     o_mb_en,
  output logic                     o_fetch,
  output logic                     o_load,
  output logic                     o_cap_opc,
  output logic                     o_cap_ext1,
  output logic                     o_cap_ext2,
  output logic                     o_inst_valid
);
  import fe_pkg::*;

  fetch_state_e state;
  fetch_state_e state_nxt;
  logic         rd;    // Memory read this cycle
  logic         xfer;  // Instruction handed over

  assign xfer = (state == S_OUT) & i_inst_ready;

  // Next state and read request
  // ----------------------------------------
  always_comb
  begin
    state_nxt = state;
    rd        = 1'b0;
    case (state)
      S_OPC:
      begin
        rd        = ~puc;  // First opcode once reset is gone
        state_nxt = S_DEC;
      end
      S_DEC:
      begin
        if (i_ext_cnt_nxt != 2'd0)
        begin
          rd        = 1'b1;  // First extension read overlaps decode
          state_nxt = S_EXT1;
        end
        else
          state_nxt = S_OUT;
      end
      S_EXT1:
      begin
        if (i_ext_cnt == 2'd2)
        begin
          rd        = 1'b1;
          state_nxt = S_EXT2;
        end
        else
          state_nxt = S_OUT;
      end
      S_EXT2:  state_nxt = S_OUT;
      S_OUT:
      begin
        // Hold here without reads until the executor takes it
        if (i_inst_ready)
        begin
          rd        = 1'b1;  // Next opcode in the handover cycle
          state_nxt = S_DEC;
        end
      end
      default: state_nxt = S_OPC;
    endcase
  end

  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
      state <= S_OPC;
    else
      state <= state_nxt;
  end

  // Strobes
  // ----------------------------------------
  assign o_mb_en      = rd;
  assign o_fetch      = rd;                  // PC steps with every read
  assign o_load       = xfer & i_pc_sw_wr;   // Redirect only on handover
  assign o_cap_opc    = (state == S_DEC);
  assign o_cap_ext1   = (state == S_EXT1);
  assign o_cap_ext2   = (state == S_EXT2);
  assign o_inst_valid = (state == S_OUT);

endmodule

`default_nettype wire

// ==== hdl/fe_pc_counter.sv ====
// Program counter
`default_nettype none

module fe_pc_counter #(
  parameter logic [fe_pkg::WORD_W-1:0] RESET_VECTOR = 16'h0000  // First fetch address
) (
  input  logic                      mclk,
  input  logic                      puc,
  input  logic                      i_fetch,  // Read issued at o_mab
  input  logic                      i_load,   // Redirect requested
  input  logic [fe_pkg::WORD_W-1:0] i_pc_sw,  // Redirect target
  output logic [fe_pkg::WORD_W-1:0] o_mab
);
  import fe_pkg::*;

  logic [WORD_W-1:0] pc;
  logic [WORD_W-1:0] pc_inc;

  // Redirect target goes straight to the bus in the same cycle
  assign o_mab  = i_load ? i_pc_sw : pc;
  assign pc_inc = o_mab + WORD_W'(2);  // Word step

  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
      pc <= RESET_VECTOR;
    else if (i_fetch)
      pc <= pc_inc;  // Past the word just read
  end

endmodule

`default_nettype wire

// ==== hdl/fe_opcode_decoder.sv ====
// Opcode decoder
`default_nettype none

module fe_opcode_decoder (
  input  logic                      mclk,
  input  logic                      puc,
  input  logic [fe_pkg::WORD_W-1:0] i_ir,           // Memory data bus
  input  logic                      i_cap_opc,      // Opcode is on i_ir
  output logic [fe_pkg::EXT_W-1:0]  o_ext_cnt_nxt,
  output logic [fe_pkg::EXT_W-1:0]  o_ext_cnt,
  output logic                      o_has_sext,     // First extension is source
  output logic [fe_pkg::WORD_W-1:0] o_sext_pre,     // Constant or jump offset
  output logic                      o_sext_pre_ld,
  output fe_pkg::inst_type_e        o_inst_type,
  output fe_pkg::so_op_e            o_so_op,
  output fe_pkg::jmp_op_e           o_jmp_op,
  output fe_pkg::to_op_e            o_to_op,
  output logic [fe_pkg::REG_W-1:0]  o_src_reg,
  output logic [fe_pkg::REG_W-1:0]  o_dst_reg,
  output fe_pkg::src_mode_e         o_src_mode,
  output fe_pkg::dst_mode_e         o_dst_mode,
  output logic                      o_inst_bw
);
  import fe_pkg::*;

  inst_type_e        type_nxt;
  logic [REG_W-1:0]  src_reg_nxt;
  logic [1:0]        as_fld;       // As field
  src_mode_e         src_mode_nxt;
  dst_mode_e         dst_mode_nxt;
  logic [WORD_W-1:0] const_val;
  logic              sext_need;
  logic              dext_need;

  // Format and registers
  // ----------------------------------------
  always_comb
  begin
    if (i_ir[15:13] == 3'b000)
      type_nxt = TYPE_SO;
    else if (i_ir[15:13] == 3'b001)
      type_nxt = TYPE_JMP;
    else
      type_nxt = TYPE_TO;
  end

  // Single-operand keeps its operand in the low nibble
  assign src_reg_nxt = (type_nxt == TYPE_SO) ? i_ir[3:0] : i_ir[11:8];
  assign as_fld      = i_ir[5:4];

  // Source mode ------------------------------
  always_comb
  begin
    if (type_nxt == TYPE_JMP)
      src_mode_nxt = REG;
    else if (src_reg_nxt == 4'h3)
      src_mode_nxt = CONST;  // CG2, every As value
    else if (src_reg_nxt == 4'h2)
    begin
      case (as_fld)          // SR doubles as CG1
        2'b00:   src_mode_nxt = REG;
        2'b01:   src_mode_nxt = ABS;
        default: src_mode_nxt = CONST;
      endcase
    end
    else if (src_reg_nxt == 4'h0)
    begin
      case (as_fld)          // PC relative forms
        2'b00:   src_mode_nxt = REG;
        2'b01:   src_mode_nxt = SYMB;
        2'b10:   src_mode_nxt = INDIR;
        default: src_mode_nxt = IMM;
      endcase
    end
    else
    begin
      case (as_fld)
        2'b00:   src_mode_nxt = REG;
        2'b01:   src_mode_nxt = IDX;
        2'b10:   src_mode_nxt = INDIR;
        default: src_mode_nxt = INDIR_INC;
      endcase
    end
  end

  // Generated constants, only used in CONST mode
  always_comb
  begin
    if (src_reg_nxt == 4'h2)
      const_val = as_fld[0] ? 16'h0008 : 16'h0004;
    else
    begin
      case (as_fld)
        2'b00:   const_val = 16'h0000;
        2'b01:   const_val = 16'h0001;
        2'b10:   const_val = 16'h0002;
        default: const_val = 16'hFFFF;
      endcase
    end
  end

  // Destination mode, Ad is bit 7
  always_comb
  begin
    if (type_nxt != TYPE_TO)
      dst_mode_nxt = D_NONE;
    else if (!i_ir[7])
      dst_mode_nxt = D_REG;
    else if (i_ir[3:0] == 4'h2)
      dst_mode_nxt = D_ABS;
    else if (i_ir[3:0] == 4'h0)
      dst_mode_nxt = D_SYMB;
    else
      dst_mode_nxt = D_IDX;
  end

  // Extension words and preset
  // ----------------------------------------
  assign sext_need = (src_mode_nxt == IDX) | (src_mode_nxt == SYMB) |
                     (src_mode_nxt == ABS) | (src_mode_nxt == IMM);
  assign dext_need = (dst_mode_nxt == D_IDX) | (dst_mode_nxt == D_SYMB) |
                     (dst_mode_nxt == D_ABS);

  assign o_ext_cnt_nxt = {1'b0, sext_need} + {1'b0, dext_need};

  assign o_sext_pre_ld = (src_mode_nxt == CONST) | (type_nxt == TYPE_JMP);
  // Jump offset is in words, signed
  assign o_sext_pre    = (type_nxt == TYPE_JMP) ? {{5{i_ir[9]}}, i_ir[9:0], 1'b0} :
                                                  const_val;

  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
    begin
      o_inst_type <= TYPE_SO;
      o_so_op     <= SO_NONE;
      o_jmp_op    <= JNE;
      o_to_op     <= TO_NONE;
      o_src_reg   <= '0;
      o_dst_reg   <= '0;
      o_src_mode  <= REG;
      o_dst_mode  <= D_NONE;
      o_inst_bw   <= 1'b0;
      o_ext_cnt   <= '0;
      o_has_sext  <= 1'b0;
    end
    else if (i_cap_opc)
    begin
      o_inst_type <= type_nxt;
      o_so_op     <= (type_nxt == TYPE_SO) ? so_op_e'(i_ir[9:7]) : SO_NONE;
      o_jmp_op    <= (type_nxt == TYPE_JMP) ? jmp_op_e'(i_ir[12:10]) : JNE;
      o_to_op     <= (type_nxt == TYPE_TO) ? to_op_e'(i_ir[15:12]) : TO_NONE;
      o_src_reg   <= src_reg_nxt;
      o_dst_reg   <= i_ir[3:0];
      o_src_mode  <= src_mode_nxt;
      o_dst_mode  <= dst_mode_nxt;
      o_inst_bw   <= i_ir[6] & (type_nxt != TYPE_JMP);  // No B/W bit in jumps
      o_ext_cnt   <= o_ext_cnt_nxt;
      o_has_sext  <= sext_need;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fe_ext_words.sv ====
// Extension word registers
`default_nettype none

module fe_ext_words (
  input  logic                      mclk,
  input  logic                      puc,
  input  logic [fe_pkg::WORD_W-1:0] i_ir,           // Memory data bus
  input  logic                      i_cap_opc,
  input  logic                      i_cap_ext1,
  input  logic                      i_cap_ext2,
  input  logic                      i_has_sext,     // Route first word to source
  input  fe_pkg::src_mode_e         i_src_mode,
  input  fe_pkg::dst_mode_e         i_dst_mode,
  input  logic [fe_pkg::WORD_W-1:0] i_sext_pre,
  input  logic                      i_sext_pre_ld,
  output logic [fe_pkg::WORD_W-1:0] o_inst_sext,
  output logic [fe_pkg::WORD_W-1:0] o_inst_dext
);
  import fe_pkg::*;

  logic [WORD_W-1:0] src_word;  // Bus word, corrected for source
  logic [WORD_W-1:0] dst_word;  // Bus word, corrected for destination
  logic              dext_wr;

  // Symbolic correction
  // ----------------------------------------
  // Modes are already latched when the extension words arrive
  assign src_word = i_ir + ((i_src_mode == SYMB) ? SYMB_ADJ : '0);
  assign dst_word = i_ir + ((i_dst_mode == D_SYMB) ? SYMB_ADJ : '0);

  // Destination takes the only word or the second one
  assign dext_wr  = (i_cap_ext1 & ~i_has_sext) | i_cap_ext2;

  // Source extension
  // ----------------------------------------
  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
      o_inst_sext <= '0;
    else if (i_cap_opc & i_sext_pre_ld)
      o_inst_sext <= i_sext_pre;    // Constant or jump offset
    else if (i_cap_ext1 & i_has_sext)
      o_inst_sext <= src_word;
  end

  // Destination extension
  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
      o_inst_dext <= '0;
    else if (dext_wr)
      o_inst_dext <= dst_word;
  end

endmodule

`default_nettype wire

// ==== hdl/fe_top.sv ====
// Fetch and decode front end
`default_nettype none

module fe_top #(
  parameter logic [fe_pkg::WORD_W-1:0] RESET_VECTOR = 16'hF000  // Start address
) (
  input  logic                      mclk,
  input  logic                      puc,
  // Program memory
  input  logic [fe_pkg::WORD_W-1:0] i_mdb_in,
  output logic [fe_pkg::WORD_W-1:0] o_mab,
  output logic                      o_mb_en,
  // Executor side
  input  logic                      i_inst_ready,
  input  logic                      i_pc_sw_wr,
  input  logic [fe_pkg::WORD_W-1:0] i_pc_sw,
  output logic                      o_inst_valid,
  output fe_pkg::inst_type_e        o_inst_type,
  output fe_pkg::so_op_e            o_so_op,
  output fe_pkg::jmp_op_e           o_jmp_op,
  output fe_pkg::to_op_e            o_to_op,
  output logic [fe_pkg::REG_W-1:0]  o_src_reg,
  output logic [fe_pkg::REG_W-1:0]  o_dst_reg,
  output fe_pkg::src_mode_e         o_src_mode,
  output fe_pkg::dst_mode_e         o_dst_mode,
  output logic                      o_inst_bw,
  output logic [fe_pkg::WORD_W-1:0] o_inst_sext,
  output logic [fe_pkg::WORD_W-1:0] o_inst_dext
);
  import fe_pkg::*;

  logic [EXT_W-1:0]  ext_cnt_nxt;
  logic [EXT_W-1:0]  ext_cnt;
  logic              has_sext;
  logic [WORD_W-1:0] sext_pre;
  logic              sext_pre_ld;
  logic              fetch;      // PC step
  logic              load;       // PC redirect
  logic              cap_opc;
  logic              cap_ext1;
  logic              cap_ext2;

  // Sequencing ------------------------------
  fe_fetch_fsm u_fsm (
    .mclk          (mclk),
    .puc           (puc),
    .i_ext_cnt_nxt (ext_cnt_nxt),
    .i_ext_cnt     (ext_cnt),
    .i_inst_ready  (i_inst_ready),
    .i_pc_sw_wr    (i_pc_sw_wr),
    .o_mb_en       (o_mb_en),
    .o_fetch       (fetch),
    .o_load        (load),
    .o_cap_opc     (cap_opc),
    .o_cap_ext1    (cap_ext1),
    .o_cap_ext2    (cap_ext2),
    .o_inst_valid  (o_inst_valid)
  );

  fe_pc_counter #(
    .RESET_VECTOR (RESET_VECTOR)
  ) u_pc (
    .mclk    (mclk),
    .puc     (puc),
    .i_fetch (fetch),
    .i_load  (load),
    .i_pc_sw (i_pc_sw),
    .o_mab   (o_mab)
  );

  // Decode ----------------------------------
  fe_opcode_decoder u_dec (
    .mclk          (mclk),
    .puc           (puc),
    .i_ir          (i_mdb_in),  // Read data is the instruction word
    .i_cap_opc     (cap_opc),
    .o_ext_cnt_nxt (ext_cnt_nxt),
    .o_ext_cnt     (ext_cnt),
    .o_has_sext    (has_sext),
    .o_sext_pre    (sext_pre),
    .o_sext_pre_ld (sext_pre_ld),
    .o_inst_type   (o_inst_type),
    .o_so_op       (o_so_op),
    .o_jmp_op      (o_jmp_op),
    .o_to_op       (o_to_op),
    .o_src_reg     (o_src_reg),
    .o_dst_reg     (o_dst_reg),
    .o_src_mode    (o_src_mode),
    .o_dst_mode    (o_dst_mode),
    .o_inst_bw     (o_inst_bw)
  );

  fe_ext_words u_ext (
    .mclk          (mclk),
    .puc           (puc),
    .i_ir          (i_mdb_in),
    .i_cap_opc     (cap_opc),
    .i_cap_ext1    (cap_ext1),
    .i_cap_ext2    (cap_ext2),
    .i_has_sext    (has_sext),
    .i_src_mode    (o_src_mode),
    .i_dst_mode    (o_dst_mode),
    .i_sext_pre    (sext_pre),
    .i_sext_pre_ld (sext_pre_ld),
    .o_inst_sext   (o_inst_sext),
    .o_inst_dext   (o_inst_dext)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_fe.sv ====
// Front end testbench
`default_nettype none

module tb_fe;
  timeunit 1ns;
  timeprecision 100ps;

  import fe_pkg::*;

  localparam logic [15:0] START     = 16'hF000;  // Reset fetch address
  localparam int          MAX_STALL = 7;         // Longest ready-low stretch

  // Expected decode of one instruction
  typedef struct packed {
    inst_type_e  typ;
    so_op_e      so;
    jmp_op_e     jo;
    to_op_e      to;
    logic [3:0]  sreg;
    logic [3:0]  dreg;
    src_mode_e   sm;
    dst_mode_e   dm;
    logic        bw;
    logic [15:0] sext;
    logic [15:0] dext;
    logic        chk_reg;   // Source register is meaningful
    logic        chk_sext;
    logic        chk_dext;
    logic        redir;     // Redirect on this handover
    logic [15:0] target;
  } inst_t;

  logic        mclk     = 1'b0;
  logic        puc;
  logic [15:0] i_mdb_in = '0;
  logic        i_inst_ready;
  logic        i_pc_sw_wr;
  logic [15:0] i_pc_sw;
  logic [15:0] o_mab;
  logic        o_mb_en;
  logic        o_inst_valid;
  inst_type_e  o_inst_type;
  so_op_e      o_so_op;
  jmp_op_e     o_jmp_op;
  to_op_e      o_to_op;
  logic [3:0]  o_src_reg;
  logic [3:0]  o_dst_reg;
  src_mode_e   o_src_mode;
  dst_mode_e   o_dst_mode;
  logic        o_inst_bw;
  logic [15:0] o_inst_sext;
  logic [15:0] o_inst_dext;

  logic [15:0] mem [0:32767];    // Word addressed program memory
  inst_t       exp_q[$];         // Instructions still to be handed over
  logic [15:0] wr_addr;          // Next program address to fill
  int          n_words;
  logic [31:0] lfsr_st;
  int          cyc       = 0;
  int          cyc_limit = 100;

  fe_top #(
    .RESET_VECTOR (START)
  ) UUT (
    .mclk (mclk), .puc (puc), .i_mdb_in (i_mdb_in), .o_mab (o_mab), .o_mb_en (o_mb_en),
    .i_inst_ready (i_inst_ready), .i_pc_sw_wr (i_pc_sw_wr), .i_pc_sw (i_pc_sw),
    .o_inst_valid (o_inst_valid), .o_inst_type (o_inst_type), .o_so_op (o_so_op),
    .o_jmp_op (o_jmp_op), .o_to_op (o_to_op), .o_src_reg (o_src_reg),
    .o_dst_reg (o_dst_reg), .o_src_mode (o_src_mode), .o_dst_mode (o_dst_mode),
    .o_inst_bw (o_inst_bw), .o_inst_sext (o_inst_sext), .o_inst_dext (o_inst_dext)
  );

  always #50 mclk = ~mclk;  // 100 ns period

  // Read data one cycle after the request
  always @(posedge mclk)
  begin
    if (o_mb_en)
      i_mdb_in <= mem[o_mab[15:1]];
  end

  // Run length guard
  always @(posedge mclk)
  begin
    cyc <= cyc + 1;
    if (cyc > cyc_limit)
      stop_with($sformatf("Timeout: no instruction handed over by cycle %0d", cyc));
  end

  // Helpers
  // ----------------------------------------
  task automatic stop_with(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  function automatic string err_line(input string msg);
    return $sformatf("ERROR at %0d ns: %s", $time, msg);
  endfunction

  // Galois LFSR stepped once per bit
  function automatic logic lfsr_bit();
    logic b;
    b       = lfsr_st[0];
    lfsr_st = lfsr_st >> 1;
    if (b)
      lfsr_st = lfsr_st ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[14:0], lfsr_bit()};
    return v;
  endfunction

  // Reference decode ------------------------
  function automatic src_mode_e ref_src_mode(input logic [3:0] r, input logic [1:0] a);
    src_mode_e m;
    m = (a == 2'd0) ? REG : (a == 2'd1) ? IDX : (a == 2'd2) ? INDIR : INDIR_INC;
    if (r == 4'd0 && a == 2'd1)
      m = SYMB;   // PC relative
    if (r == 4'd0 && a == 2'd3)
      m = IMM;    // @PC+
    if (r == 4'd2 && a == 2'd1)
      m = ABS;
    if ((r == 4'd2 && a[1]) || r == 4'd3)
      m = CONST;  // Constant generators
    return m;
  endfunction

  function automatic logic [15:0] ref_const(input logic [3:0] r, input logic [1:0] a);
    logic [15:0] cg3 [0:3];
    cg3[0] = 16'h0000;
    cg3[1] = 16'h0001;
    cg3[2] = 16'h0002;
    cg3[3] = 16'hFFFF;
    if (r == 4'd2)
      return (a == 2'd2) ? 16'h0004 : 16'h0008;
    return cg3[a];
  endfunction

  function automatic inst_t blank();
    inst_t e;
    e         = '0;
    e.so      = SO_NONE;  // Unused opcode fields
    e.jo      = JNE;
    e.to      = TO_NONE;
    e.chk_reg = 1'b1;
    return e;
  endfunction

  // Program building ------------------------
  task automatic emit(input logic [15:0] w);
    mem[wr_addr[15:1]] = w;
    wr_addr            = wr_addr + 16'd2;
    n_words++;
  endtask

  // Source operand and its extension word
  task automatic add_src(inout inst_t e, input logic [3:0] r, input logic [1:0] a,
                         input logic [15:0] w);
    e.sreg = r;
    e.sm   = ref_src_mode(r, a);
    if (e.sm == CONST)
    begin
      e.sext     = ref_const(r, a);
      e.chk_sext = 1'b1;
    end
    else if (e.sm inside {IDX, ABS, IMM, SYMB})
    begin
      emit(w);
      e.sext     = (e.sm == SYMB) ? w - 16'd2 : w;  // PC already past the word
      e.chk_sext = 1'b1;
    end
  endtask

  task automatic add_to(input to_op_e op, input logic [3:0] sr, input logic [1:0] a,
                        input logic bw, input logic [3:0] dr, input logic ad,
                        input logic [15:0] sw, input logic [15:0] dw);
    inst_t e;
    e      = blank();
    e.typ  = TYPE_TO;
    e.to   = op;
    e.bw   = bw;
    e.dreg = dr;
    emit({4'(op), sr, ad, bw, a, dr});
    add_src(e, sr, a, sw);
    if (!ad)
      e.dm = D_REG;
    else
    begin
      e.dm       = (dr == 4'd0) ? D_SYMB : (dr == 4'd2) ? D_ABS : D_IDX;
      emit(dw);  // Always after the source word
      e.dext     = (e.dm == D_SYMB) ? dw - 16'd2 : dw;
      e.chk_dext = 1'b1;
    end
    exp_q.push_back(e);
  endtask

  task automatic add_so(input so_op_e op, input logic bw, input logic [1:0] a,
                        input logic [3:0] r, input logic [15:0] w);
    inst_t e;
    e     = blank();
    e.typ = TYPE_SO;
    e.so  = op;
    e.bw  = bw;
    emit({6'b000100, 3'(op), bw, a, r});
    add_src(e, r, a, w);
    exp_q.push_back(e);
  endtask

  task automatic add_jmp(input jmp_op_e c, input logic [9:0] off);
    inst_t e;
    int    words;
    e          = blank();
    e.typ      = TYPE_JMP;
    e.jo       = c;
    e.chk_reg  = 1'b0;
    words      = int'($signed(off));
    e.sext     = 16'(words * 2);  // Offset in bytes
    e.chk_sext = 1'b1;
    emit({3'b001, 3'(c), off});
    exp_q.push_back(e);
  endtask

  task automatic set_redirect(input logic [15:0] target);
    inst_t e;
    e        = exp_q.pop_back();
    e.redir  = 1'b1;
    e.target = target;
    exp_q.push_back(e);
  endtask

  // Running and checking
  // ----------------------------------------
  task automatic check_fields(input inst_t e);
    assert (o_inst_type == e.typ && o_so_op == e.so && o_jmp_op == e.jo && o_to_op == e.to)
    else stop_with(err_line($sformatf("opcode %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d",
      o_inst_type, o_so_op, o_jmp_op, o_to_op, e.typ, e.so, e.jo, e.to)));
    assert ((!e.chk_reg || o_src_reg == e.sreg) && (e.typ != TYPE_TO || o_dst_reg == e.dreg))
    else stop_with(err_line($sformatf("registers %0d,%0d, expected %0d,%0d",
      o_src_reg, o_dst_reg, e.sreg, e.dreg)));
    assert (o_src_mode == e.sm && o_dst_mode == e.dm && o_inst_bw == e.bw)
    else stop_with(err_line($sformatf("modes %0d/%0d bw %b, expected %0d/%0d bw %b",
      o_src_mode, o_dst_mode, o_inst_bw, e.sm, e.dm, e.bw)));
    assert (!e.chk_sext || o_inst_sext == e.sext)
    else stop_with(err_line($sformatf("sext %h, expected %h", o_inst_sext, e.sext)));
    assert (!e.chk_dext || o_inst_dext == e.dext)
    else stop_with(err_line($sformatf("dext %h, expected %h", o_inst_dext, e.dext)));
  endtask

  // Hold reset while the next program is written
  task automatic start_test();
    cyc_limit = cyc + 20;
    @(posedge mclk);
    puc          <= 1'b1;
    i_inst_ready <= 1'b0;
    i_pc_sw_wr   <= 1'b0;
    repeat (3)
    begin
      @(negedge mclk);
      assert (!o_inst_valid && !o_mb_en)
      else stop_with(err_line("valid or read enable high during reset"));
    end
    exp_q.delete();
    wr_addr = START;
    n_words = 0;
  endtask

  task automatic run_prog(input logic stall);
    int stall_left;
    stall_left = 0;
    cyc_limit  = cyc + n_words * (MAX_STALL + 4) + 20;
    @(posedge mclk);
    puc          <= 1'b0;
    i_inst_ready <= 1'b1;
    i_pc_sw_wr   <= exp_q[0].redir;
    i_pc_sw      <= exp_q[0].target;
    @(negedge mclk);
    assert (o_mb_en && o_mab == START)
    else stop_with(err_line($sformatf("first read at %h, enable %b", o_mab, o_mb_en)));
    while (exp_q.size() > 0)
    begin
      @(posedge mclk);
      i_inst_ready <= (stall_left == 0);
      i_pc_sw_wr   <= exp_q[0].redir;   // Only sampled on the handover
      i_pc_sw      <= exp_q[0].target;
      if (stall_left > 0)
        stall_left--;
      @(negedge mclk);
      if (o_inst_valid)
      begin
        check_fields(exp_q[0]);  // Repeated in stalled cycles to see the fields hold
        if (i_inst_ready)
        begin
          assert (o_mb_en && (!exp_q[0].redir || o_mab == exp_q[0].target))
          else stop_with(err_line($sformatf("next read at %h, enable %b", o_mab, o_mb_en)));
          void'(exp_q.pop_front());
          if (stall)
            stall_left = int'(rand_bits(3));
        end
        else
          assert (!o_mb_en) else stop_with(err_line("read issued while stalled"));
      end
    end
  endtask

  // Tests
  // ----------------------------------------
  task automatic test_single_word();
    start_test();
    for (int op = 4; op < 16; op++)
      add_to(to_op_e'(4'(op)), 4'(rand_bits(4)), 2'd0, 1'(rand_bits(1)),
             4'(rand_bits(4)), 1'b0, 16'h0000, 16'h0000);
    for (int op = 0; op < 7; op++)
      add_so(so_op_e'(3'(op)), 1'(rand_bits(1)), 2'd0, 4'(rand_bits(4)), 16'h0000);
    for (int c = 0; c < 8; c++)
      add_jmp(jmp_op_e'(3'(c)), 10'(rand_bits(10)));
    add_jmp(JMP, 10'h3FF);  // Minus one word
    add_jmp(JNE, 10'h200);  // Furthest back
    run_prog(1'b0);
  endtask

  task automatic test_multi_word();
    start_test();
    add_to(MOV, 4'd5, 2'd1, 1'b0, 4'd6, 1'b0, rand_bits(16), 16'h0);   // IDX
    add_to(ADD, 4'd2, 2'd1, 1'b1, 4'd7, 1'b0, rand_bits(16), 16'h0);   // ABS
    add_to(SUB, 4'd0, 2'd3, 1'b0, 4'd8, 1'b0, rand_bits(16), 16'h0);   // IMM
    add_to(CMP, 4'd0, 2'd1, 1'b0, 4'd9, 1'b0, rand_bits(16), 16'h0);   // SYMB
    add_to(BIS, 4'd10, 2'd2, 1'b0, 4'd1, 1'b1, 16'h0, rand_bits(16));
    add_to(XOR, 4'd11, 2'd3, 1'b1, 4'd0, 1'b1, 16'h0, rand_bits(16));
    add_to(AND, 4'd0, 2'd1, 1'b0, 4'd0, 1'b1, rand_bits(16), rand_bits(16));
    add_to(MOV, 4'd2, 2'd1, 1'b0, 4'd2, 1'b1, rand_bits(16), rand_bits(16));
    add_to(BIC, 4'd4, 2'd1, 1'b1, 4'd12, 1'b1, rand_bits(16), rand_bits(16));
    add_to(DADD, 4'd0, 2'd3, 1'b0, 4'd2, 1'b1, rand_bits(16), rand_bits(16));
    add_so(PUSH, 1'b0, 2'd1, 4'd5, rand_bits(16));
    add_so(CALL, 1'b0, 2'd3, 4'd0, rand_bits(16));
    run_prog(1'b0);
  endtask

  // Every As value of both generators
  task automatic test_const_gen();
    start_test();
    for (int a = 0; a < 4; a++)
    begin
      add_to(ADD, 4'd2, 2'(a), 1'b0, 4'd4, 1'b0, rand_bits(16), 16'h0);
      add_to(SUB, 4'd3, 2'(a), 1'b1, 4'd5, 1'b0, 16'h0, 16'h0);
      add_so(RRA, 1'b0, 2'(a), 4'd3, 16'h0);
    end
    run_prog(1'b0);
  endtask

  task automatic test_back_pressure();
    logic [1:0] kind;
    logic [3:0] op;
    logic [2:0] so;
    start_test();
    for (int i = 0; i < 16; i++)
    begin
      kind = 2'(rand_bits(2));
      if (kind == 2'd0)
        add_jmp(jmp_op_e'(3'(rand_bits(3))), 10'(rand_bits(10)));
      else if (kind == 2'd1)
      begin
        so = 3'(rand_bits(3));
        if (so == 3'd7)
          so = 3'd4;  // No illegal code
        add_so(so_op_e'(so), 1'(rand_bits(1)), 2'(rand_bits(2)), 4'(rand_bits(4)),
               rand_bits(16));
      end
      else
      begin
        op = 4'(rand_bits(4));
        if (op < 4'd4)
          op = op + 4'd8;
        add_to(to_op_e'(op), 4'(rand_bits(4)), 2'(rand_bits(2)), 1'(rand_bits(1)),
               4'(rand_bits(4)), 1'(rand_bits(1)), rand_bits(16), rand_bits(16));
      end
    end
    run_prog(1'b1);
  endtask

  task automatic test_redirect();
    start_test();
    add_to(MOV, 4'd4, 2'd0, 1'b0, 4'd5, 1'b0, 16'h0, 16'h0);
    set_redirect(16'hF100);
    emit(16'h4A0B);  // Must be skipped
    wr_addr = 16'hF100;
    add_to(ADD, 4'd0, 2'd3, 1'b0, 4'd6, 1'b0, rand_bits(16), 16'h0);
    set_redirect(16'hF20A);
    emit(16'h5B0C);  // Must be skipped
    wr_addr = 16'hF20A;
    add_jmp(JC, 10'h015);
    run_prog(1'b1);
  endtask

  initial
  begin
    puc          = 1'b1;
    i_inst_ready = 1'b0;
    i_pc_sw_wr   = 1'b0;
    i_pc_sw      = '0;
    lfsr_st      = 32'h9691_1d40;
    for (int a = 0; a < 32768; a++)
      mem[a] = 16'(a * 2) ^ 16'hC3A5;  // Address-dependent fill
    test_single_word();
    test_multi_word();
    test_const_gen();
    test_back_pressure();
    test_redirect();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/fe_pkg.sv
hdl/fe_fetch_fsm.sv
hdl/fe_pc_counter.sv
hdl/fe_opcode_decoder.sv
hdl/fe_ext_words.sv
hdl/fe_top.sv
testbench/tb_fe.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/100ps -f list.f --top-module tb_fe -o tb_fe
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_fe > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
